// ==== logic/div_pkg.sv ====
package div_pkg;

  // Data path width
  localparam int xlen   = 32;
  localparam int iter_w = 6;  // Holds iteration counts 0 to 32
  localparam int acc_w  = 8;

  // M extension encodings
  localparam logic [6:0] opcode_op     = 7'b0110011;  // R-type integer ops
  localparam logic [6:0] funct7_muldiv = 7'b0000001;  // MUL and DIV group

  typedef logic [xlen-1:0]   word_t;  // Operands and results
  typedef logic [acc_w-1:0]  acc_t;   // Accuracy level from the core
  typedef logic [iter_w-1:0] iter_t;  // Quotient bits to compute

  // Exact run produces one bit per data bit
  localparam iter_t full_iters = iter_t'(xlen);

  // Order follows funct3[1:0]
  typedef enum logic [1:0] {
    op_div,   // 100
    op_divu,  // 101
    op_rem,   // 110
    op_remu   // 111
  } div_op_e;

  typedef enum logic [1:0] {
    st_idle,  // Waiting for start
    st_prep,  // Operands ready, core loads
    st_run,   // One quotient bit per cycle
    st_fix    // Sign and select, output registered
  } ctrl_state_e;

  // Instruction fields relevant to the decode
  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
  } insn_t;

  typedef struct packed {
    word_t   mag_a;     // Dividend magnitude
    word_t   mag_b;     // Divisor magnitude
    logic    neg_q;     // Operand signs differ
    logic    neg_r;     // Dividend negative
    logic    div_zero;
    word_t   raw_a;     // Original dividend for the zero divisor case
    iter_t   iters;
    div_op_e op;
  } prep_t;

  typedef struct packed {
    word_t quot;
    word_t rem;
  } core_res_t;

endpackage

// ==== logic/div_decode.sv ====
`timescale 1ns/1ps

module div_decode (
  input  logic            CLK,
  input  logic            reset,
  input  logic            cap_en,
  input  div_pkg::insn_t  insn,
  output div_pkg::div_op_e op,
  output logic            legal
);

  logic is_op;
  logic is_muldiv;
  logic is_div_group;

  // Start decision needs the live instruction
  assign is_op        = (insn.opcode == div_pkg::opcode_op);
  assign is_muldiv    = (insn.funct7 == div_pkg::funct7_muldiv);
  assign is_div_group = insn.funct3[2];  // 100 to 111 only

  assign legal = is_op & is_muldiv & is_div_group;

  // Operation held for the whole divide
  // so the core may move on to other instructions
  always_ff @(posedge CLK) begin
    if (reset) begin
      op <= div_pkg::op_div;
    end else if (cap_en) begin
      // Low funct3 bits map straight onto the enum
      op <= div_pkg::div_op_e'(insn.funct3[1:0]);
    end
  end

endmodule

// ==== logic/div_operand_prep.sv ====
`timescale 1ns/1ps

module div_operand_prep #(
  parameter int unsigned apx_acc_control = 1  // 1 enables truncated quotient
) (
  input  logic             CLK,
  input  logic             reset,
  input  logic             cap_en,
  input  div_pkg::div_op_e op,
  input  div_pkg::word_t   rs1,
  input  div_pkg::word_t   rs2,
  input  div_pkg::acc_t    accuracy_level,
  output div_pkg::prep_t   prep
);

  div_pkg::word_t a_q;    // Captured dividend
  div_pkg::word_t b_q;    // Captured divisor
  div_pkg::acc_t  acc_q;
  logic           is_signed;
  logic           sign_a;
  logic           sign_b;
  logic           b_zero;
  div_pkg::iter_t iters;

  always_ff @(posedge CLK) begin
    if (reset) begin
      a_q   <= '0;
      b_q   <= '0;
      acc_q <= '0;
    end else if (cap_en) begin
      a_q   <= rs1;
      b_q   <= rs2;
      acc_q <= accuracy_level;
    end
  end

  assign is_signed = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
  assign sign_a    = is_signed & a_q[div_pkg::xlen-1];
  assign sign_b    = is_signed & b_q[div_pkg::xlen-1];
  assign b_zero    = (b_q == '0);

  // Iteration count
  always_comb begin
    if (b_zero) iters = '0;  // Skip the run state entirely
    else if (apx_acc_control == 0) iters = div_pkg::full_iters;
    else if (acc_q == '0 || acc_q >= div_pkg::acc_t'(div_pkg::xlen)) begin
      iters = div_pkg::full_iters;  // Out of range means exact
    end else begin
      iters = acc_q[div_pkg::iter_w-1:0];
    end
  end

  always_comb begin
    prep.mag_a    = sign_a ? -a_q : a_q;  // Most negative stays as 2^31
    prep.mag_b    = sign_b ? -b_q : b_q;
    prep.neg_q    = sign_a ^ sign_b;
    prep.neg_r    = sign_a;  // Remainder takes the dividend sign
    prep.div_zero = b_zero;
    prep.raw_a    = a_q;
    prep.iters    = iters;
    prep.op       = op;
  end

endmodule

// ==== logic/div_core.sv ====
`timescale 1ns/1ps

module div_core (
  input  logic               CLK,
  input  logic               reset,
  input  logic               load,
  input  logic               step,
  input  div_pkg::prep_t     prep,
  output div_pkg::core_res_t core
);

  div_pkg::word_t  rem_q;   // Partial remainder
  div_pkg::word_t  quot_q;  // Quotient bits so far, right aligned
  div_pkg::word_t  dvd_q;   // Dividend, unprocessed bits at the top
  div_pkg::iter_t  left_q;  // Dividend bits not yet processed

  logic [div_pkg::xlen:0] shifted;  // Remainder with next dividend bit
  logic [div_pkg::xlen:0] trial;
  logic                   q_bit;

  // Restoring step
  assign shifted = {rem_q, dvd_q[div_pkg::xlen-1]};
  assign trial   = shifted - {1'b0, prep.mag_b};
  assign q_bit   = ~trial[div_pkg::xlen];  // No borrow means divisor fits

  always_ff @(posedge CLK) begin
    if (reset) begin
      rem_q  <= '0;
      quot_q <= '0;
      left_q <= '0;
    end else if (load) begin
      rem_q  <= '0;
      quot_q <= '0;
      left_q <= div_pkg::full_iters;
    end else if (step) begin
      // Keep the difference only when the subtract succeeds
      rem_q  <= q_bit ? trial[div_pkg::xlen-1:0] : shifted[div_pkg::xlen-1:0];
      quot_q <= {quot_q[div_pkg::xlen-2:0], q_bit};
      left_q <= left_q - 1'b1;
    end
  end

  // Dividend shift register
  always_ff @(posedge CLK) begin
    if (load) begin
      dvd_q <= prep.mag_a;
    end else if (step) begin
      dvd_q <= {dvd_q[div_pkg::xlen-2:0], 1'b0};
    end
  end

  // Realign to full width
  // untouched low dividend bits fill the remainder
  always_comb begin
    core.quot = quot_q << left_q;
    core.rem  = (rem_q << left_q) | (dvd_q >> (div_pkg::xlen - left_q));
  end

endmodule

// ==== logic/div_control.sv ====
`timescale 1ns/1ps

module div_control (
  input  logic           CLK,
  input  logic           reset,
  input  logic           start,
  input  logic           legal,
  input  div_pkg::iter_t iters,
  output logic           cap_en,
  output logic           load,
  output logic           step,
  output logic           fix_en,
  output logic           busy
);

  div_pkg::ctrl_state_e state;
  div_pkg::ctrl_state_e state_nxt;
  div_pkg::iter_t       iter_cnt;  // Run cycles still to go
  logic                 accept;

  // Start only counts when idle and decodes as a divide
  assign accept = (state == div_pkg::st_idle) & start & legal;

  always_comb begin
    state_nxt = state;
    case (state)
      div_pkg::st_idle: begin
        if (accept) state_nxt = div_pkg::st_prep;
      end
      div_pkg::st_prep: begin
        // Zero divisor has no quotient bits to produce
        if (iters == '0) state_nxt = div_pkg::st_fix;
        else state_nxt = div_pkg::st_run;
      end
      div_pkg::st_run: begin
        if (iter_cnt == div_pkg::iter_t'(1)) state_nxt = div_pkg::st_fix;  // Last bit
      end
      div_pkg::st_fix: state_nxt = div_pkg::st_idle;
      default: state_nxt = div_pkg::st_idle;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state <= div_pkg::st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Down-counter of run cycles
  always_ff @(posedge CLK) begin
    if (reset) begin
      iter_cnt <= '0;
    end else if (state == div_pkg::st_prep) begin
      iter_cnt <= iters;  // Loaded alongside the core
    end else if (state == div_pkg::st_run) begin
      iter_cnt <= iter_cnt - 1'b1;
    end
  end

  // Strobes decoded from the state
  assign cap_en = accept;
  assign load   = (state == div_pkg::st_prep);
  assign step   = (state == div_pkg::st_run);
  assign fix_en = (state == div_pkg::st_fix);
  assign busy   = (state != div_pkg::st_idle);  // High for k + 2 cycles

endmodule

// ==== logic/div_result_fix.sv ====
`timescale 1ns/1ps

module div_result_fix (
  input  logic               CLK,
  input  logic               reset,
  input  logic               fix_en,
  input  div_pkg::prep_t     prep,
  input  div_pkg::core_res_t core,
  output div_pkg::word_t     div_output
);

  div_pkg::word_t quot_fix;
  div_pkg::word_t rem_fix;
  div_pkg::word_t result;
  logic           want_quot;

  // Signs and the divide by zero rule
  always_comb begin
    if (prep.div_zero) begin
      quot_fix = '1;          // All ones by the ISA rule
      rem_fix  = prep.raw_a;  // Dividend returned unchanged
    end else begin
      quot_fix = prep.neg_q ? -core.quot : core.quot;
      rem_fix  = prep.neg_r ? -core.rem : core.rem;
    end
  end

  assign want_quot = (prep.op == div_pkg::op_div) || (prep.op == div_pkg::op_divu);
  assign result    = want_quot ? quot_fix : rem_fix;

  // Held until the next divide completes
  always_ff @(posedge CLK) begin
    if (reset) begin
      div_output <= '0;
    end else if (fix_en) begin
      div_output <= result;
    end
  end

endmodule

// ==== logic/div_unit.sv ====
`timescale 1ns/1ps

module div_unit #(
  parameter int unsigned apx_acc_control = 1
) (
  input  logic           CLK,
  input  logic           reset,
  input  logic           start,
  input  div_pkg::insn_t insn,
  input  div_pkg::acc_t  accuracy_level,
  input  div_pkg::word_t rs1,
  input  div_pkg::word_t rs2,
  output logic           busy,
  output div_pkg::word_t div_output
);

  div_pkg::div_op_e   op;
  logic               legal;
  logic               cap_en;
  logic               load;
  logic               step;
  logic               fix_en;
  div_pkg::prep_t     prep;
  div_pkg::core_res_t core;

  div_decode decode_i (.CLK, .reset, .cap_en, .insn, .op, .legal);

  div_operand_prep #(
    .apx_acc_control(apx_acc_control)
  ) operand_prep_i (
    .CLK, .reset, .cap_en, .op, .rs1, .rs2, .accuracy_level, .prep
  );

  div_core core_i (.CLK, .reset, .load, .step, .prep, .core);

  // Counter loads from the prepared iteration count
  div_control control_i (
    .CLK, .reset, .start, .legal, .iters(prep.iters),
    .cap_en, .load, .step, .fix_en, .busy
  );

  div_result_fix result_fix_i (.CLK, .reset, .fix_en, .prep, .core, .div_output);

endmodule

// ==== sim/div_unit_asserts.sv ====
`timescale 1ns/1ps

module div_unit_asserts (
  input logic                 CLK,
  input logic                 reset,
  input div_pkg::ctrl_state_e state,
  input logic                 step,
  input logic                 fix_en,
  input logic                 busy
);

  int fail_cnt = 0;  // Failed assertion count

  // Control back in idle right after reset
  reset_idle: assert property (@(posedge CLK) reset |=> !busy)
    else begin
      fail_cnt++;
      $error("busy high one cycle after reset");
    end

  // Run state only reached through prep
  step_in_run: assert property (@(posedge CLK) disable iff (reset)
                                step |-> $past(state == div_pkg::st_prep ||
                                               state == div_pkg::st_run))
    else begin
      fail_cnt++;
      $error("step without a prep or run cycle before it");
    end

  // Result written once, then the unit is free
  fix_then_idle: assert property (@(posedge CLK) disable iff (reset)
                                  fix_en |=> !fix_en && !busy)
    else begin
      fail_cnt++;
      $error("fix_en longer than one cycle or busy still high");
    end

endmodule

bind div_control div_unit_asserts asserts_i (
  .CLK, .reset, .state, .step, .fix_en, .busy
);

// ==== sim/div_unit_tb.sv ====
`timescale 1ns/1ps

module div_unit_tb;

  localparam int n_tests     = 62;  // 32 exact, 8 corners, 4 zero, 16 approx, 2 ignored
  localparam int cycle_limit = n_tests * 40 + 100;

  logic           CLK;
  logic           reset;
  logic           start;
  div_pkg::insn_t insn;
  div_pkg::acc_t  accuracy_level;
  div_pkg::word_t rs1;
  div_pkg::word_t rs2;
  logic           busy;
  div_pkg::word_t div_output;

  logic [31:0] lfsr = 32'h204d;
  int cycles = 0;
  int errors = 0;  // Individual check failures
  int tests  = 0;
  int failed = 0;  // Tests with at least one failed check

  div_unit #(.apx_acc_control(1)) div_unit_i (
    .CLK, .reset, .start, .insn, .accuracy_level, .rs1, .rs2, .busy, .div_output
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;  // 4 ns period
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Run did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // Galois LFSR shifting right, taps 32 22 2 1, one step per bit taken
  function automatic div_pkg::word_t rand_bits(int n);
    div_pkg::word_t v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // R-type encodings of the four divide instructions
  function automatic div_pkg::insn_t insn_of(div_pkg::div_op_e op);
    div_pkg::insn_t i;
    i.opcode = 7'b0110011;
    i.funct7 = 7'b0000001;
    case (op)
      div_pkg::op_div:  i.funct3 = 3'b100;
      div_pkg::op_divu: i.funct3 = 3'b101;
      div_pkg::op_rem:  i.funct3 = 3'b110;
      default:          i.funct3 = 3'b111;
    endcase
    return i;
  endfunction

  function automatic int model_iters(div_pkg::word_t b, div_pkg::acc_t acc);
    if (b == 0) return 0;  // No run state at all
    if (acc == 0 || acc >= 32) return 32;
    return acc;
  endfunction

  // Reference result, s low dividend bits left unprocessed
  function automatic div_pkg::word_t model_result(div_pkg::div_op_e op, div_pkg::word_t a,
                                                  div_pkg::word_t b, div_pkg::acc_t acc);
    logic           sgn;
    logic           quot_op;
    div_pkg::word_t ma, mb, q, r, low;
    int             s;
    sgn     = (op == div_pkg::op_div) || (op == div_pkg::op_rem);
    quot_op = (op == div_pkg::op_div) || (op == div_pkg::op_divu);
    if (b == 0) return quot_op ? '1 : a;
    ma  = (sgn && a[31]) ? -a : a;
    mb  = (sgn && b[31]) ? -b : b;
    s   = 32 - model_iters(b, acc);
    low = div_pkg::word_t'((64'd1 << s) - 1);
    q   = ((ma >> s) / mb) << s;
    r   = (((ma >> s) % mb) << s) | (ma & low);
    if (sgn && (a[31] ^ b[31])) q = -q;
    if (sgn && a[31]) r = -r;  // Remainder follows the dividend
    return quot_op ? q : r;
  endfunction

  task automatic check_word(div_pkg::word_t expected, div_pkg::word_t actual);
    if (actual !== expected) begin
      $display("[ERROR] div_output expected %h actual %h", expected, actual);
      errors++;
    end
  endtask

  task automatic check_busy(div_pkg::iter_t expected, div_pkg::iter_t actual);
    if (actual !== expected) begin
      $display("Busy stayed high for %0d cycles instead of %0d", actual, expected);
      errors++;
    end
  endtask

  task automatic report(string what, int err0);
    tests++;
    if (errors != err0) failed++;
    $display("Test %0d %s %s", tests, what, (errors == err0) ? "ok" : "FAILED");
  endtask

  // One divide, with a second start pulsed mid-run when stray is set
  task automatic run_divide(div_pkg::div_op_e op, div_pkg::word_t a, div_pkg::word_t b,
                            div_pkg::acc_t acc, logic stray);
    int n;
    int err0;
    n    = 0;
    err0 = errors;
    @(posedge CLK);
    start          <= 1'b1;
    insn           <= insn_of(op);
    rs1            <= a;
    rs2            <= b;
    accuracy_level <= acc;
    @(posedge CLK);
    start <= 1'b0;  // Accepted on this edge
    @(negedge CLK);
    while (busy) begin
      n++;
      if (stray && n == 2) begin
        @(posedge CLK);
        start <= 1'b1;
        insn  <= insn_of(div_pkg::op_rem);
        rs1   <= ~a;
        rs2   <= 32'd3;
      end else if (stray && n == 3) begin
        @(posedge CLK);
        start <= 1'b0;
      end
      @(negedge CLK);
    end
    check_busy(div_pkg::iter_t'(model_iters(b, acc) + 2), div_pkg::iter_t'(n));
    check_word(model_result(op, a, b, acc), div_output);
    report($sformatf("%s a=%h b=%h acc=%0d", op.name(), a, b, acc), err0);
  endtask

  // MUL encoding, same opcode and funct7 but outside the divide group
  task automatic illegal_start();
    div_pkg::word_t held;
    int             err0;
    held = div_output;
    err0 = errors;
    @(posedge CLK);
    start <= 1'b1;
    insn  <= '{opcode: 7'b0110011, funct3: 3'b000, funct7: 7'b0000001};
    rs1   <= 32'd99;
    rs2   <= 32'd5;
    @(posedge CLK);
    start <= 1'b0;
    repeat (4) begin
      @(negedge CLK);
      if (busy) begin
        $display("Busy rose for a start with a MUL instruction");
        errors++;
      end
    end
    check_word(held, div_output);
    report("illegal start ignored", err0);
  endtask

  initial begin
    reset          = 1'b1;
    start          = 1'b0;
    insn           = '0;
    accuracy_level = '0;
    rs1            = '0;
    rs2            = '0;
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
    // Exact, divisor shifted down so quotients vary in length
    for (int i = 0; i < 32; i++) begin
      run_divide(div_pkg::div_op_e'(i % 4), rand_bits(32), rand_bits(32) >> rand_bits(5),
                 8'd0, 1'b0);
    end
    run_divide(div_pkg::op_div, -32'sd7, 32'd2, 8'd0, 1'b0);  // Mixed signs
    run_divide(div_pkg::op_div, 32'd7, -32'sd2, 8'd0, 1'b0);
    run_divide(div_pkg::op_div, -32'sd7, -32'sd2, 8'd0, 1'b0);
    run_divide(div_pkg::op_rem, -32'sd7, 32'd2, 8'd0, 1'b0);
    run_divide(div_pkg::op_rem, 32'd7, -32'sd2, 8'd0, 1'b0);
    run_divide(div_pkg::op_rem, -32'sd100, 32'd7, 8'd0, 1'b0);
    run_divide(div_pkg::op_div, 32'h8000_0000, 32'hFFFF_FFFF, 8'd0, 1'b0);  // Overflow
    run_divide(div_pkg::op_rem, 32'h8000_0000, 32'hFFFF_FFFF, 8'd0, 1'b0);
    for (int i = 0; i < 4; i++) begin
      run_divide(div_pkg::div_op_e'(i), rand_bits(32), 32'd0, 8'd0, 1'b0);
    end
    // Truncated quotient, levels 1 to 31
    for (int i = 0; i < 16; i++) begin
      run_divide(div_pkg::div_op_e'(i % 4), rand_bits(32), rand_bits(32) >> rand_bits(5),
                 div_pkg::acc_t'(rand_bits(5) % 31 + 1), 1'b0);
    end
    run_divide(div_pkg::op_divu, 32'd1000, 32'd7, 8'd0, 1'b1);
    illegal_start();
    $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d", tests,
             tests - failed, failed, div_unit_i.control_i.asserts_i.fail_cnt);
    if (failed == 0 && div_unit_i.control_i.asserts_i.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/div_pkg.sv
logic/div_decode.sv
logic/div_operand_prep.sv
logic/div_core.sv
logic/div_control.sv
logic/div_result_fix.sv
logic/div_unit.sv
sim/div_unit_asserts.sv
sim/div_unit_tb.sv
